// ==== bench/kvs_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvs_props
	import mig_pkg::*;
(
	input wire            ui_mig_clk,
	input wire            ui_mig_rst,
	input wire            app_en,
	input wire            app_rdy,
	input wire            app_wdf_rdy,
	input wire mig_cmd_t  app_cmd,
	input wire mig_addr_t app_addr,
	input wire            app_rd_data_valid,
	input wire            out_valid
);

	// ------------------------------------------------------------
	// lookup latency
	// ------------------------------------------------------------
	a_read_to_result: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		app_rd_data_valid |-> ##2 out_valid)
		else $error("out_valid missing two cycles after read data");

	a_result_from_read: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		out_valid |-> $past(app_rd_data_valid, 2))
		else $error("out_valid without read data two cycles earlier");

	// ------------------------------------------------------------
	// command interface
	// ------------------------------------------------------------
	// only a write may drop app_en, and only while app_wdf_rdy is low
	a_cmd_hold: assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		app_en && !app_rdy |=> $stable(app_addr) && $stable(app_cmd) &&
			(app_en || (app_cmd == MIG_CMD_WRITE && !app_wdf_rdy)))
		else $error("command changed before acceptance");

endmodule

bind kvs_dram_cont kvs_props u_props (.*);

`default_nettype wire

// ==== bench/kvs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvs_tb
	import mig_pkg::*, kvs_pkg::*;
();

	localparam int RESET_CYCLES   = 5;
	localparam int ORDER_BUCKETS  = 8;
	localparam int STALL_BUCKETS  = 12;
	// rough cycle budgets per test
	localparam int RESET_TEST_LEN = 80;
	localparam int SET_TEST_LEN   = 100;
	localparam int HIT_TEST_LEN   = 150;
	localparam int ORDER_TEST_LEN = 200;
	localparam int STALL_TEST_LEN = 800;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + RESET_TEST_LEN + SET_TEST_LEN +
		HIT_TEST_LEN + ORDER_TEST_LEN + STALL_TEST_LEN);

	logic       ui_mig_clk;
	logic       ui_mig_rst;
	logic       init_calib_complete;
	logic       in_valid;
	kvs_op_t    in_op;
	kvs_hash_t  in_hash;
	kvs_key_t   in_key;
	kvs_value_t in_value;
	mig_addr_t  app_addr;
	mig_cmd_t   app_cmd;
	logic       app_en;
	logic       app_rdy;
	mig_data_t  app_wdf_data;
	logic       app_wdf_end;
	mig_mask_t  app_wdf_mask;
	logic       app_wdf_rdy;
	logic       app_wdf_wren;
	mig_data_t  app_rd_data;
	logic       app_rd_data_valid;
	logic       out_valid;
	kvs_flag_t  out_flag;
	logic       rdy_stall;
	logic       wdf_stall;
	logic       stall_en;

	logic [31:0] lcg_state = 32'h2d93;
	logic [31:0] stall_state = 32'h2d93;
	int          cycle_count = 0;
	int          next_bucket;
	kvs_flag_t   flag_q [$];
	logic [1:0]  rdv_hist;
	logic        hold_prev;
	mig_addr_t   hold_addr;
	mig_cmd_t    hold_cmd;

	kvs_dram_cont #(.QUEUE_DEPTH_LOG2(6)) u_dut (
		.ui_mig_clk (ui_mig_clk), .ui_mig_rst (ui_mig_rst),
		.init_calib_complete (init_calib_complete),
		.in_valid (in_valid), .in_op (in_op), .in_hash (in_hash),
		.in_key (in_key), .in_value (in_value),
		.app_addr (app_addr), .app_cmd (app_cmd), .app_en (app_en), .app_rdy (app_rdy),
		.app_wdf_data (app_wdf_data), .app_wdf_end (app_wdf_end),
		.app_wdf_mask (app_wdf_mask), .app_wdf_rdy (app_wdf_rdy),
		.app_wdf_wren (app_wdf_wren), .app_rd_data (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid),
		.out_valid (out_valid), .out_flag (out_flag)
	);

	mig_model u_mem (
		.ui_mig_clk (ui_mig_clk), .ui_mig_rst (ui_mig_rst),
		.app_addr (app_addr), .app_cmd (app_cmd), .app_en (app_en), .app_rdy (app_rdy),
		.app_wdf_data (app_wdf_data), .app_wdf_end (app_wdf_end),
		.app_wdf_mask (app_wdf_mask), .app_wdf_rdy (app_wdf_rdy),
		.app_wdf_wren (app_wdf_wren), .app_rd_data (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid),
		.rdy_stall (rdy_stall), .wdf_stall (wdf_stall)
	);

	initial begin
		ui_mig_clk = 1'b0;
		forever #4 ui_mig_clk = ~ui_mig_clk;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] lcg_step(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [31:0] next_rand();
		lcg_state = lcg_step(lcg_state);
		return lcg_state;
	endfunction

	function kvs_key_t random_key();
		return {next_rand(), next_rand(), next_rand()};
	endfunction

	// new bucket per call with random bits outside the bucket field
	function kvs_hash_t fresh_hash();
		logic [31:0] r;
		r = next_rand();
		next_bucket = next_bucket + 1;
		return {r[31:30], next_bucket[23:0], r[5:0]};
	endfunction

	task automatic fail_test(string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_flag(string name, kvs_flag_t expected, kvs_flag_t actual);
		if (actual !== expected)
			fail_test($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_addr(string name, mig_addr_t expected, mig_addr_t actual);
		if (actual !== expected)
			fail_test($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_mask(string name, mig_mask_t expected, mig_mask_t actual);
		if (actual !== expected)
			fail_test($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_slot(string name, kvs_slot_t expected, kvs_slot_t actual);
		if (actual !== expected)
			fail_test($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_count(string name, int expected, int actual);
		if (actual !== expected)
			fail_test($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic send_request(kvs_op_t op, kvs_hash_t hash, kvs_key_t key, kvs_value_t value);
		@(negedge ui_mig_clk);
		in_valid = 1'b1;
		in_op    = op;
		in_hash  = hash;
		in_key   = key;
		in_value = value;
		@(negedge ui_mig_clk);
		in_valid = 1'b0;
	endtask

	task automatic wait_writes(int total);
		while (u_mem.wr_count < total)
			@(negedge ui_mig_clk);
	endtask

	task automatic wait_flags(int n);
		while (flag_q.size() < n)
			@(negedge ui_mig_clk);
	endtask

	// one logged write against the set that caused it
	task automatic check_write(string name, int idx, kvs_hash_t hash, kvs_key_t key,
		kvs_value_t value);
		kvs_bucket_t line;
		mig_mask_t   mask;
		int          slot;
		slot = 0;
		mask = u_mem.log_mask[idx];
		line = u_mem.log_data[idx];
		check_addr(name, hash[29:0] & 30'h3fff_ffc0, u_mem.log_addr[idx]);
		for (int s = 0; s < 4; s++) begin
			if (mask[s*16 +: 16] == 16'h0)
				slot = s;
		end
		check_mask(name, ~(64'hffff << (slot * 16)), mask);
		check_slot(name, {key, value}, line[slot]);
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_reset();
		kvs_hash_t  h0;
		kvs_hash_t  h1;
		kvs_key_t   k;
		kvs_value_t v;
		repeat (RESET_CYCLES) begin
			@(negedge ui_mig_clk);
			if (out_valid !== 1'b0 || app_en !== 1'b0 || app_wdf_wren !== 1'b0)
				fail_test("outputs active during reset");
		end
		ui_mig_rst = 1'b0;
		h0 = fresh_hash();
		h1 = fresh_hash();
		k  = random_key();
		v  = next_rand();
		send_request(OP_SET, h0, k, v);
		send_request(OP_GET, h1, k, v);
		// nothing may leave while calibration is pending
		repeat (20) @(negedge ui_mig_clk);
		check_count("reset no commands", 0, u_mem.wr_count + u_mem.rd_count);
		init_calib_complete = 1'b1;
		wait_writes(1);
		wait_flags(1);
		check_flag("reset untouched get", FLAG_MISS, flag_q.pop_front());
		check_write("reset set", 0, h0, k, v);
	endtask

	task automatic test_set_writes();
		kvs_hash_t  hashes [4];
		kvs_key_t   keys [4];
		kvs_value_t values [4];
		int         base;
		base = u_mem.wr_count;
		for (int i = 0; i < 4; i++) begin
			hashes[i] = fresh_hash();
			keys[i]   = random_key();
			values[i] = next_rand();
			send_request(OP_SET, hashes[i], keys[i], values[i]);
		end
		wait_writes(base + 4);
		for (int i = 0; i < 4; i++)
			check_write("set writes", base + i, hashes[i], keys[i], values[i]);
	endtask

	task automatic test_hit_miss();
		kvs_hash_t  h;
		kvs_key_t   k;
		kvs_value_t v;
		int         base;
		h    = fresh_hash();
		k    = random_key();
		v    = next_rand();
		base = u_mem.wr_count;
		send_request(OP_GET, h, k, v);
		wait_flags(1);
		check_flag("miss before set", FLAG_MISS, flag_q.pop_front());
		send_request(OP_SET, h, k, v);
		wait_writes(base + 1);
		// low hash bits do not select the bucket
		send_request(OP_GET, {h[31:6], ~h[5:0]}, k, v);
		send_request(OP_GET, h, k ^ 96'h1, v);
		wait_flags(2);
		check_flag("hit after set", FLAG_HIT, flag_q.pop_front());
		check_flag("other key miss", FLAG_MISS, flag_q.pop_front());
	endtask

	task automatic test_ordering(string name, int n, logic stall);
		kvs_hash_t hashes [16];
		kvs_key_t  keys [16];
		kvs_flag_t expect_flag [16];
		int        wr_base;
		int        rd_base;
		int        writes;
		wr_base  = u_mem.wr_count;
		rd_base  = u_mem.rd_count;
		writes   = 0;
		stall_en = stall;
		for (int i = 0; i < n; i++) begin
			hashes[i] = fresh_hash();
			keys[i]   = random_key();
			expect_flag[i] = FLAG_MISS;
			if (i % 3 != 1) begin
				send_request(OP_SET, hashes[i], keys[i], next_rand());
				expect_flag[i] = FLAG_HIT;
				writes++;
			end
		end
		wait_writes(wr_base + writes);
		for (int i = 0; i < n; i++) begin
			send_request(OP_GET, hashes[i], keys[i], '0);
			// keeps both queues busy at once
			if (stall) begin
				send_request(OP_SET, fresh_hash(), random_key(), next_rand());
				writes++;
			end
		end
		wait_flags(n);
		for (int i = 0; i < n; i++)
			check_flag(name, expect_flag[i], flag_q.pop_front());
		stall_en = 1'b0;
		wait_writes(wr_base + writes);
		repeat (20) @(negedge ui_mig_clk);
		check_count({name, " writes"}, writes, u_mem.wr_count - wr_base);
		check_count({name, " reads"}, n, u_mem.rd_count - rd_base);
		check_count({name, " extra results"}, 0, flag_q.size());
	endtask

	// ------------------------------------------------------------
	// monitors
	// ------------------------------------------------------------
	always @(negedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			rdv_hist  <= '0;
			hold_prev <= 1'b0;
		end else begin
			if (out_valid)
				flag_q.push_back(out_flag);
			if (out_valid !== rdv_hist[1])
				fail_test("out_valid did not follow a read return by two cycles");
			if (hold_prev && (app_addr !== hold_addr || app_cmd !== hold_cmd))
				fail_test("command changed before it was accepted");
			if (hold_prev && !app_en && (hold_cmd == MIG_CMD_READ || app_wdf_rdy))
				fail_test("command withdrawn before it was accepted");
			if (app_en && !init_calib_complete)
				fail_test("command issued before calibration completed");
			rdv_hist  <= {rdv_hist[0], app_rd_data_valid};
			hold_prev <= app_en && !app_rdy;
			hold_addr <= app_addr;
			hold_cmd  <= app_cmd;
		end
	end

	// random back-pressure on its own stream
	always @(negedge ui_mig_clk) begin
		if (stall_en) begin
			stall_state = lcg_step(stall_state);
			rdy_stall   = stall_state[27];
			wdf_stall   = stall_state[29];
		end else begin
			rdy_stall = 1'b0;
			wdf_stall = 1'b0;
		end
	end

	always @(posedge ui_mig_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, DUT stopped responding", cycle_count);
			$display("Test failed");
			$fatal(1);
		end
	end

	initial begin
		ui_mig_rst          = 1'b1;
		init_calib_complete = 1'b0;
		in_valid            = 1'b0;
		in_op               = OP_GET;
		in_hash             = '0;
		in_key              = '0;
		in_value            = '0;
		rdy_stall           = 1'b0;
		wdf_stall           = 1'b0;
		stall_en            = 1'b0;
		next_bucket         = 1;
		test_reset();
		test_set_writes();
		test_hit_miss();
		test_ordering("ordering", ORDER_BUCKETS, 1'b0);
		test_ordering("back-pressure", STALL_BUCKETS, 1'b1);
		check_count("malformed writes", 0, u_mem.bad_write);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/mig_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mig_model
	import mig_pkg::*;
#(
	parameter int RD_LATENCY = 4,
	parameter int LOG_DEPTH  = 256
) (
	input  wire            ui_mig_clk,
	input  wire            ui_mig_rst,
	input  wire mig_addr_t app_addr,
	input  wire mig_cmd_t  app_cmd,
	input  wire            app_en,
	output logic           app_rdy,
	input  wire mig_data_t app_wdf_data,
	input  wire            app_wdf_end,
	input  wire mig_mask_t app_wdf_mask,
	output logic           app_wdf_rdy,
	input  wire            app_wdf_wren,
	output mig_data_t      app_rd_data,
	output logic           app_rd_data_valid,
	input  wire            rdy_stall,
	input  wire            wdf_stall
);

	// sparse line store, untouched lines read as zero
	mig_data_t store [mig_addr_t];

	// write log, one entry per accepted write
	mig_addr_t log_addr [LOG_DEPTH];
	mig_mask_t log_mask [LOG_DEPTH];
	mig_data_t log_data [LOG_DEPTH];
	int        wr_count = 0;
	int        rd_count = 0;
	int        bad_write = 0;

	logic [RD_LATENCY-1:0] rd_pipe_v;
	mig_data_t             rd_pipe_d [RD_LATENCY];
	logic                  take;

	function automatic mig_data_t line_at(mig_addr_t addr);
		if (store.exists(addr))
			return store[addr];
		return '0;
	endfunction

	// a set mask bit keeps the old byte
	function automatic mig_data_t merge_line(mig_data_t old, mig_data_t data, mig_mask_t mask);
		mig_data_t res;
		res = old;
		for (int b = 0; b < 64; b++) begin
			if (!mask[b])
				res[b*8 +: 8] = data[b*8 +: 8];
		end
		return res;
	endfunction

	assign take              = app_en && app_rdy;
	assign app_rd_data_valid = rd_pipe_v[RD_LATENCY-1];
	assign app_rd_data       = rd_pipe_d[RD_LATENCY-1];

	always @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			app_rdy     <= 1'b0;
			app_wdf_rdy <= 1'b0;
			rd_pipe_v   <= '0;
		end else begin
			app_rdy     <= !rdy_stall;
			app_wdf_rdy <= !wdf_stall;
			// fixed latency keeps returns in issue order
			rd_pipe_v    <= {rd_pipe_v[RD_LATENCY-2:0], take && (app_cmd == MIG_CMD_READ)};
			rd_pipe_d[0] <= line_at(app_addr);
			for (int i = 1; i < RD_LATENCY; i++)
				rd_pipe_d[i] <= rd_pipe_d[i-1];
			if (take && app_cmd == MIG_CMD_READ)
				rd_count <= rd_count + 1;
			if (take && app_cmd == MIG_CMD_WRITE) begin
				if (!(app_wdf_wren && app_wdf_end && app_wdf_rdy))
					bad_write <= bad_write + 1;
				store[app_addr] = merge_line(line_at(app_addr), app_wdf_data, app_wdf_mask);
				if (wr_count < LOG_DEPTH) begin
					log_addr[wr_count] <= app_addr;
					log_mask[wr_count] <= app_wdf_mask;
					log_data[wr_count] <= app_wdf_data;
				end
				wr_count <= wr_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/mig_pkg.sv
verilog/kvs_pkg.sv
verilog/sync_fifo.sv
verilog/set_packer.sv
verilog/cmd_arbiter.sv
verilog/bucket_lookup.sv
verilog/kvs_dram_cont.sv
bench/mig_model.sv
bench/kvs_props.sv
bench/kvs_tb.sv

// ==== verilog/bucket_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module bucket_lookup
	import mig_pkg::*, kvs_pkg::*;
(
	input  wire               ui_mig_clk,
	input  wire               ui_mig_rst,
	input  wire               app_rd_data_valid,
	input  wire mig_data_t    app_rd_data,
	input  wire pending_get_t pending,
	output logic              pending_pop,
	output logic              out_valid,
	output kvs_flag_t         out_flag
);

	// ------------------------------------------------------------
	// stage one, capture line and waiting key
	// ------------------------------------------------------------
	logic        s1_valid;
	kvs_bucket_t s1_line;
	kvs_key_t    s1_key;
	logic        hit;

	// reads come back in issue order, so the head key belongs here
	assign pending_pop = app_rd_data_valid;

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= app_rd_data_valid;
	end

	always_ff @(posedge ui_mig_clk) begin
		if (app_rd_data_valid) begin
			s1_line <= kvs_bucket_t'(app_rd_data);
			s1_key  <= pending.key;
		end
	end

	// ------------------------------------------------------------
	// stage two, slot compare
	// ------------------------------------------------------------
	always_comb begin
		hit = 1'b0;
		for (int i = 0; i < SLOTS; i++) begin
			if (s1_line[i].key == s1_key)
				hit = 1'b1;
		end
	end

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			out_valid <= 1'b0;
		else
			out_valid <= s1_valid;
	end

	// value is not returned, only presence
	always_ff @(posedge ui_mig_clk) begin
		if (s1_valid)
			out_flag <= hit ? FLAG_HIT : FLAG_MISS;
	end

endmodule

`default_nettype wire

// ==== verilog/cmd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter
	import mig_pkg::*, kvs_pkg::*;
(
	input  wire          ui_mig_clk,
	input  wire          ui_mig_rst,
	input  wire          init_calib_complete,
	input  wire rd_cmd_t rd_cmd,
	input  wire          rd_empty,
	output logic         rd_pop,
	input  wire wr_cmd_t wr_cmd,
	input  wire          wr_empty,
	output logic         wr_pop,
	input  wire          app_rdy,
	input  wire          app_wdf_rdy,
	output logic         app_en,
	output mig_cmd_t     app_cmd,
	output mig_addr_t    app_addr,
	output mig_data_t    app_wdf_data,
	output mig_mask_t    app_wdf_mask,
	output logic         app_wdf_wren,
	output logic         app_wdf_end
);

	// read goes first after reset
	logic turn_rd;
	// an offer that was not yet taken stays locked
	logic held;
	logic held_rd;
	logic sel_rd;
	logic offer;
	logic accept;

	always_comb begin
		if (held)
			sel_rd = held_rd;
		else if (!rd_empty && !wr_empty)
			sel_rd = turn_rd;
		else
			sel_rd = !rd_empty;
		// write data must be takeable alongside the command
		if (sel_rd)
			offer = init_calib_complete && !rd_empty;
		else
			offer = init_calib_complete && !wr_empty && app_wdf_rdy;
	end

	assign accept = offer && app_rdy;
	assign rd_pop = accept && sel_rd;
	assign wr_pop = accept && !sel_rd;

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			turn_rd <= 1'b1;
			held    <= 1'b0;
			held_rd <= 1'b0;
		end else if (accept) begin
			turn_rd <= !sel_rd;
			held    <= 1'b0;
		end else if (offer) begin
			held    <= 1'b1;
			held_rd <= sel_rd;
		end
	end

	// ------------------------------------------------------------
	// user interface drive
	// ------------------------------------------------------------
	assign app_en       = offer;
	assign app_cmd      = sel_rd ? MIG_CMD_READ : MIG_CMD_WRITE;
	assign app_addr     = sel_rd ? rd_cmd.addr : wr_cmd.addr;
	assign app_wdf_data = wr_cmd.data;
	assign app_wdf_mask = wr_cmd.mask;
	// single beat per line
	assign app_wdf_wren = offer && !sel_rd;
	assign app_wdf_end  = offer && !sel_rd;

endmodule

`default_nettype wire

// ==== verilog/kvs_dram_cont.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvs_dram_cont
	import mig_pkg::*, kvs_pkg::*;
#(
	parameter int QUEUE_DEPTH_LOG2 = 6
) (
	input  wire             ui_mig_clk,
	input  wire             ui_mig_rst,
	input  wire             init_calib_complete,
	input  wire             in_valid,
	input  wire kvs_op_t    in_op,
	input  wire kvs_hash_t  in_hash,
	input  wire kvs_key_t   in_key,
	input  wire kvs_value_t in_value,
	output mig_addr_t       app_addr,
	output mig_cmd_t        app_cmd,
	output logic            app_en,
	input  wire             app_rdy,
	output mig_data_t       app_wdf_data,
	output logic            app_wdf_end,
	output mig_mask_t       app_wdf_mask,
	input  wire             app_wdf_rdy,
	output logic            app_wdf_wren,
	input  wire mig_data_t  app_rd_data,
	input  wire             app_rd_data_valid,
	output logic            out_valid,
	output kvs_flag_t       out_flag
);

	logic         set_strobe;
	logic         get_strobe;
	logic         wr_push;
	wr_cmd_t      wr_cmd_in;
	wr_cmd_t      wr_cmd_head;
	logic         wr_pop;
	logic         wr_empty;
	rd_cmd_t      rd_cmd_in;
	rd_cmd_t      rd_cmd_head;
	logic         rd_pop;
	logic         rd_empty;
	pending_get_t pending_in;
	pending_get_t pending_head;
	logic         pending_pop;

	// ------------------------------------------------------------
	// request decode
	// ------------------------------------------------------------
	assign set_strobe = in_valid && (in_op == OP_SET);
	assign get_strobe = in_valid && (in_op == OP_GET);

	assign rd_cmd_in.addr = bucket_addr(in_hash);
	assign pending_in.key = in_key;

	set_packer u_set_packer (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.set_strobe (set_strobe),
		.hash       (in_hash),
		.key        (in_key),
		.value      (in_value),
		.wr_push    (wr_push),
		.wr_cmd     (wr_cmd_in)
	);

	// ------------------------------------------------------------
	// command and key queues
	// ------------------------------------------------------------
	sync_fifo #(.payload_t(wr_cmd_t), .QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)) u_wr_queue (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (wr_push),
		.push_data  (wr_cmd_in),
		.pop        (wr_pop),
		.pop_data   (wr_cmd_head),
		.empty      (wr_empty),
		.full       ()
	);

	sync_fifo #(.payload_t(rd_cmd_t), .QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)) u_rd_queue (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (get_strobe),
		.push_data  (rd_cmd_in),
		.pop        (rd_pop),
		.pop_data   (rd_cmd_head),
		.empty      (rd_empty),
		.full       ()
	);

	// empty never read, pops track read returns one for one
	sync_fifo #(.payload_t(pending_get_t), .QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)) u_pending_queue (
		.ui_mig_clk (ui_mig_clk),
		.ui_mig_rst (ui_mig_rst),
		.push       (get_strobe),
		.push_data  (pending_in),
		.pop        (pending_pop),
		.pop_data   (pending_head),
		.empty      (),
		.full       ()
	);

	cmd_arbiter u_cmd_arbiter (
		.ui_mig_clk          (ui_mig_clk),
		.ui_mig_rst          (ui_mig_rst),
		.init_calib_complete (init_calib_complete),
		.rd_cmd              (rd_cmd_head),
		.rd_empty            (rd_empty),
		.rd_pop              (rd_pop),
		.wr_cmd              (wr_cmd_head),
		.wr_empty            (wr_empty),
		.wr_pop              (wr_pop),
		.app_rdy             (app_rdy),
		.app_wdf_rdy         (app_wdf_rdy),
		.app_en              (app_en),
		.app_cmd             (app_cmd),
		.app_addr            (app_addr),
		.app_wdf_data        (app_wdf_data),
		.app_wdf_mask        (app_wdf_mask),
		.app_wdf_wren        (app_wdf_wren),
		.app_wdf_end         (app_wdf_end)
	);

	bucket_lookup u_bucket_lookup (
		.ui_mig_clk        (ui_mig_clk),
		.ui_mig_rst        (ui_mig_rst),
		.app_rd_data_valid (app_rd_data_valid),
		.app_rd_data       (app_rd_data),
		.pending           (pending_head),
		.pending_pop       (pending_pop),
		.out_valid         (out_valid),
		.out_flag          (out_flag)
	);

endmodule

`default_nettype wire

// ==== verilog/kvs_pkg.sv ====
`default_nettype none

// ------------------------------------------------------------
// key-value request and bucket layout
// ------------------------------------------------------------
package kvs_pkg;
	import mig_pkg::*;

	typedef logic [31:0] kvs_hash_t;
	typedef logic [95:0] kvs_key_t;
	typedef logic [31:0] kvs_value_t;

	// key sits above value inside a slot
	typedef struct packed {
		kvs_key_t   key;
		kvs_value_t value;
	} kvs_slot_t;

	localparam int SLOTS = 4;

	// slot 0 in the low 128 bits of the line
	typedef kvs_slot_t [SLOTS-1:0] kvs_bucket_t;
	typedef logic [1:0] slot_idx_t;

	typedef logic [3:0] kvs_flag_t;
	localparam kvs_flag_t FLAG_HIT  = 4'd1;
	localparam kvs_flag_t FLAG_MISS = 4'd0;

	typedef logic kvs_op_t;
	localparam kvs_op_t OP_SET = 1'b1;
	localparam kvs_op_t OP_GET = 1'b0;

	typedef struct packed {
		mig_addr_t addr;
		mig_data_t data;
		mig_mask_t mask;
	} wr_cmd_t;

	typedef struct packed {
		mig_addr_t addr;
	} rd_cmd_t;

	// key parked until its bucket read returns
	typedef struct packed {
		kvs_key_t key;
	} pending_get_t;

	// hash bits above the line offset, offset forced to zero
	function automatic mig_addr_t bucket_addr(kvs_hash_t hash);
		return {hash[29:BUCKET_OFFSET_BITS], {BUCKET_OFFSET_BITS{1'b0}}};
	endfunction

endpackage

`default_nettype wire

// ==== verilog/mig_pkg.sv ====
`default_nettype none

// ------------------------------------------------------------
// controller user interface
// ------------------------------------------------------------
package mig_pkg;

	// word address as seen on app_addr
	typedef logic [29:0] mig_addr_t;

	typedef logic [2:0] mig_cmd_t;

	localparam mig_cmd_t MIG_CMD_READ  = 3'b001;
	localparam mig_cmd_t MIG_CMD_WRITE = 3'b000;

	// one full burst, 8 beats of 64 bits
	typedef logic [511:0] mig_data_t;

	// byte mask, a set bit keeps the byte unwritten
	typedef logic [63:0] mig_mask_t;

	// a bucket line spans 64 address units
	localparam int BUCKET_OFFSET_BITS = 6;

endpackage

`default_nettype wire

// ==== verilog/set_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module set_packer
	import mig_pkg::*, kvs_pkg::*;
(
	input  wire             ui_mig_clk,
	input  wire             ui_mig_rst,
	input  wire             set_strobe,
	input  wire kvs_hash_t  hash,
	input  wire kvs_key_t   key,
	input  wire kvs_value_t value,
	output logic            wr_push,
	output wr_cmd_t         wr_cmd
);

	localparam int SLOT_BYTES = $bits(kvs_slot_t) / 8;

	slot_idx_t   lfsr;
	kvs_slot_t   slot;
	kvs_bucket_t line;
	mig_mask_t   mask;

	// ------------------------------------------------------------
	// replacement choice
	// ------------------------------------------------------------
	// x^2 + x + 1, cycles 01 -> 11 -> 10, never all zero
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			lfsr <= 2'b01;
		else
			lfsr <= {lfsr[0], lfsr[1] ^ lfsr[0]};
	end

	// ------------------------------------------------------------
	// line and mask assembly
	// ------------------------------------------------------------
	always_comb begin
		slot.key   = key;
		slot.value = value;
		line       = '0;
		line[lfsr] = slot;
		// only the chosen slot's bytes get written
		mask = '1;
		mask[lfsr*SLOT_BYTES +: SLOT_BYTES] = '0;
	end

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			wr_push <= 1'b0;
		else
			wr_push <= set_strobe;
	end

	always_ff @(posedge ui_mig_clk) begin
		if (set_strobe) begin
			wr_cmd.addr <= bucket_addr(hash);
			wr_cmd.data <= line;
			wr_cmd.mask <= mask;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type payload_t     = logic,
	parameter int QUEUE_DEPTH_LOG2 = 6
) (
	input  wire           ui_mig_clk,
	input  wire           ui_mig_rst,
	input  wire           push,
	input  wire payload_t push_data,
	input  wire           pop,
	output payload_t      pop_data,
	output logic          empty,
	output logic          full
);

	localparam int DEPTH = 1 << QUEUE_DEPTH_LOG2;

	payload_t mem [DEPTH];

	// extra top bit tells full from empty
	logic [QUEUE_DEPTH_LOG2:0] wr_ptr;
	logic [QUEUE_DEPTH_LOG2:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[QUEUE_DEPTH_LOG2] != rd_ptr[QUEUE_DEPTH_LOG2]) &&
		(wr_ptr[QUEUE_DEPTH_LOG2-1:0] == rd_ptr[QUEUE_DEPTH_LOG2-1:0]);

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge ui_mig_clk) begin
		if (do_push)
			mem[wr_ptr[QUEUE_DEPTH_LOG2-1:0]] <= push_data;
	end

	// head word visible without a pop
	assign pop_data = mem[rd_ptr[QUEUE_DEPTH_LOG2-1:0]];

endmodule

`default_nettype wire
